/* logic/mem_types_pkg.sv */
`default_nettype none

package mem_types_pkg;

    // native memory side of the write port
    localparam int be_addr_w = 16;
    localparam int be_data_w = 64;
    localparam int be_nbytes = be_data_w / 8;
    localparam int be_byte_w = $clog2(be_nbytes);   // byte offset inside one beat

    // one beat on the native port
    typedef struct packed
    {
        logic [be_addr_w-1:0] addr;     // always aligned to be_nbytes
        logic [be_data_w-1:0] wdata;
        logic [be_nbytes-1:0] wstrb;
    } mem_beat_t;

endpackage

`default_nettype wire

/* logic/fe_types_pkg.sv */
`default_nettype none

package fe_types_pkg;

    // front-end word and address
    localparam int addr_w    = 16;
    localparam int fe_data_w = 32;
    localparam int fe_nbytes = fe_data_w / 8;
    localparam int fe_byte_w = $clog2(fe_nbytes);   // byte offset inside one word

    // cache line geometry
    localparam int words_per_line = 4;
    localparam int beats_per_line = 2;
    localparam int line_w         = words_per_line * fe_data_w;
    localparam int line_off_w     = $clog2(line_w / 8);    // 16-byte lines
    localparam int line_addr_w    = addr_w - line_off_w;

    // single write-through store
    typedef struct packed
    {
        logic [addr_w-1:0]    addr;     // byte address
        logic [fe_nbytes-1:0] wstrb;
        logic [fe_data_w-1:0] wdata;
    } wt_req_t;

    // dirty line leaving the cache
    typedef struct packed
    {
        logic [line_addr_w-1:0] line_addr;   // address above the line offset
        logic [line_w-1:0]      line_data;   // word 0 in the low bits
    } evict_req_t;

endpackage

`default_nettype wire

/* logic/write_through_buffer.sv */
`default_nettype none

module write_through_buffer
    import fe_types_pkg::*, mem_types_pkg::*;
#(
    parameter int wt_depth = 4
)
(
    input  wire             clk,
    input  wire             reset,
    input  wire wt_req_t    wt_req,
    input  wire             wt_valid,
    output logic            wt_ready,
    output mem_beat_t       wt_beat,
    output logic            wt_beat_valid,
    input  wire             wt_beat_pop
);

    localparam int ptr_w  = $clog2(wt_depth);
    localparam int lane_w = be_byte_w - fe_byte_w;   // index bits of the word lane in a beat

    wt_req_t              fifo_mem [wt_depth];
    logic [ptr_w-1:0]     wr_ptr;
    logic [ptr_w-1:0]     rd_ptr;
    logic [ptr_w:0]       count;
    logic                 full;
    logic                 push;
    wt_req_t              head;
    logic [lane_w-1:0]    lane;

    assign full          = (count == (ptr_w+1)'(wt_depth));
    assign wt_beat_valid = (count != '0);
    assign wt_ready      = ~full | wt_beat_pop;     // a pop frees the slot in the same edge
    assign push          = wt_valid & wt_ready;

    // store payloads
    always_ff @(posedge clk)
    begin
        if (push)
        begin
            fifo_mem[wr_ptr] <= wt_req;
        end
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
            begin
                wr_ptr <= wr_ptr + 1'b1;    // wraps since depth is a power of two
            end
            if (wt_beat_pop)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, wt_beat_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // both or neither
            endcase
        end
    end

    assign head = fifo_mem[rd_ptr];
    assign lane = head.addr[be_byte_w-1:fe_byte_w];

    // head store placed on its lane of the wide bus
    always_comb
    begin
        wt_beat.addr  = {head.addr[addr_w-1:be_byte_w], {be_byte_w{1'b0}}};
        wt_beat.wdata = {(be_data_w / fe_data_w){head.wdata}};   // word on every lane
        wt_beat.wstrb = be_nbytes'(head.wstrb) << (lane * fe_nbytes);
    end

endmodule

`default_nettype wire

/* logic/line_evict_serializer.sv */
`default_nettype none

module line_evict_serializer
    import fe_types_pkg::*, mem_types_pkg::*;
(
    input  wire             clk,
    input  wire             reset,
    input  wire evict_req_t evict_req,
    input  wire             evict_valid,
    output logic            evict_ready,
    output mem_beat_t       ev_beat,
    output logic            ev_beat_valid,
    input  wire             ev_beat_taken
);

    localparam int beat_cnt_w = $clog2(beats_per_line);

    evict_req_t              line_q;        // held dirty line
    logic                    line_held;
    logic [beat_cnt_w-1:0]   beat_cnt;      // next beat to send
    logic                    accept;
    logic                    last_beat;

    assign evict_ready   = ~line_held;
    assign ev_beat_valid = line_held;
    assign accept        = evict_valid & evict_ready;
    assign last_beat     = (beat_cnt == beat_cnt_w'(beats_per_line - 1));

    // line payload, loaded only while empty
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            line_q <= evict_req;
        end
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            line_held <= 1'b0;
            beat_cnt  <= '0;
        end
        else if (accept)
        begin
            line_held <= 1'b1;
            beat_cnt  <= '0;
        end
        else if (ev_beat_taken)
        begin
            if (last_beat)
            begin
                line_held <= 1'b0;          // free again after the final beat
                beat_cnt  <= '0;
            end
            else
            begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

    // beat k sits at line base plus k beats
    always_comb
    begin
        ev_beat.addr  = {line_q.line_addr, beat_cnt, {be_byte_w{1'b0}}};
        ev_beat.wdata = line_q.line_data[beat_cnt * be_data_w +: be_data_w];
        ev_beat.wstrb = '1;                 // evictions write whole beats
    end

endmodule

`default_nettype wire

/* logic/mem_write_control.sv */
`default_nettype none

module mem_write_control
    import mem_types_pkg::*;
(
    input  wire             clk,
    input  wire             reset,
    input  wire mem_beat_t  wt_beat,
    input  wire             wt_beat_valid,
    output logic            wt_beat_pop,
    input  wire mem_beat_t  ev_beat,
    input  wire             ev_beat_valid,
    output logic            ev_beat_taken,
    output mem_beat_t       mem_beat,
    output logic            mem_valid,
    input  wire             mem_ready,
    input  wire [1:0]       busy_sources,
    output logic            write_idle
);

    logic   pend_q;         // beat left on the port last cycle
    logic   pend_ev_q;      // its source, 1 for eviction
    logic   sel_ev;
    logic   xfer;

    // a pending beat keeps its source, otherwise evictions win
    always_comb
    begin
        if (pend_q)
        begin
            sel_ev = pend_ev_q;
        end
        else
        begin
            sel_ev = ev_beat_valid;
        end
    end

    // port mux, purely combinational
    always_comb
    begin
        if (sel_ev)
        begin
            mem_beat  = ev_beat;
            mem_valid = ev_beat_valid;
        end
        else
        begin
            mem_beat  = wt_beat;
            mem_valid = wt_beat_valid;
        end
    end

    assign xfer          = mem_valid & mem_ready;
    assign ev_beat_taken = xfer & sel_ev;
    assign wt_beat_pop   = xfer & ~sel_ev;

    // grant register, follows the beat until memory accepts it
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            pend_q    <= 1'b0;
            pend_ev_q <= 1'b0;
        end
        else
        begin
            pend_q    <= mem_valid & ~mem_ready;
            pend_ev_q <= sel_ev;
        end
    end

    // bit 0 buffer not empty, bit 1 line held
    assign write_idle = ~(|busy_sources) & ~mem_valid;

endmodule

`default_nettype wire

/* logic/mem_write_port.sv */
`default_nettype none

module mem_write_port
    import fe_types_pkg::*, mem_types_pkg::*;
#(
    parameter int wt_depth = 4
)
(
    input  wire             clk,
    input  wire             reset,
    input  wire wt_req_t    wt_req,
    input  wire             wt_valid,
    output logic            wt_ready,
    input  wire evict_req_t evict_req,
    input  wire             evict_valid,
    output logic            evict_ready,
    output mem_beat_t       mem_beat,
    output logic            mem_valid,
    input  wire             mem_ready,
    output logic            write_idle
);

    mem_beat_t  wt_beat;
    logic       wt_beat_valid;
    logic       wt_beat_pop;
    mem_beat_t  ev_beat;
    logic       ev_beat_valid;
    logic       ev_beat_taken;
    logic [1:0] busy_sources;

    // a held line always shows as a valid eviction beat
    assign busy_sources = {ev_beat_valid, wt_beat_valid};

    write_through_buffer #(
        .wt_depth       (wt_depth)
    ) write_through_buffer_inst (
        .clk            (clk),
        .reset          (reset),
        .wt_req         (wt_req),
        .wt_valid       (wt_valid),
        .wt_ready       (wt_ready),
        .wt_beat        (wt_beat),
        .wt_beat_valid  (wt_beat_valid),
        .wt_beat_pop    (wt_beat_pop)
    );

    line_evict_serializer line_evict_serializer_inst (
        .clk            (clk),
        .reset          (reset),
        .evict_req      (evict_req),
        .evict_valid    (evict_valid),
        .evict_ready    (evict_ready),
        .ev_beat        (ev_beat),
        .ev_beat_valid  (ev_beat_valid),
        .ev_beat_taken  (ev_beat_taken)
    );

    mem_write_control mem_write_control_inst (
        .clk            (clk),
        .reset          (reset),
        .wt_beat        (wt_beat),
        .wt_beat_valid  (wt_beat_valid),
        .wt_beat_pop    (wt_beat_pop),
        .ev_beat        (ev_beat),
        .ev_beat_valid  (ev_beat_valid),
        .ev_beat_taken  (ev_beat_taken),
        .mem_beat       (mem_beat),
        .mem_valid      (mem_valid),
        .mem_ready      (mem_ready),
        .busy_sources   (busy_sources),
        .write_idle     (write_idle)
    );

endmodule

`default_nettype wire

/* verif/mem_write_port_assertions.sv */
`default_nettype none

module mem_write_port_assertions
    import mem_types_pkg::*;
(
    input  wire             clk,
    input  wire             reset,
    input  wire mem_beat_t  mem_beat,
    input  wire             mem_valid,
    input  wire             mem_ready,
    input  wire             wt_beat_valid,
    input  wire             wt_beat_pop,
    input  wire             ev_beat_valid,
    input  wire             ev_beat_taken
);

    // stalled beat stays on the port unchanged
    hold_until_ready: assert property (@(posedge clk) disable iff (reset)
        mem_valid && !mem_ready |=> mem_valid && $stable(mem_beat))
        else $error("native beat dropped or changed before mem_ready");

    one_source: assert property (@(posedge clk) disable iff (reset)
        !(ev_beat_taken && wt_beat_pop))
        else $error("pop and taken high in the same cycle");

    quiet_in_reset: assert property (@(posedge clk)
        reset |-> !mem_valid && !wt_beat_valid && !ev_beat_valid)
        else $error("valid raised while in reset");

endmodule

bind mem_write_control mem_write_port_assertions mem_write_port_assertions_inst (
    .clk            (clk),
    .reset          (reset),
    .mem_beat       (mem_beat),
    .mem_valid      (mem_valid),
    .mem_ready      (mem_ready),
    .wt_beat_valid  (wt_beat_valid),
    .wt_beat_pop    (wt_beat_pop),
    .ev_beat_valid  (ev_beat_valid),
    .ev_beat_taken  (ev_beat_taken)
);

`default_nettype wire

/* verif/mem_write_port_tb.sv */
`default_nettype none

module mem_write_port_tb
    import fe_types_pkg::*, mem_types_pkg::*;
();

    localparam int wt_depth   = 4;
    localparam int n_stores   = 200;
    localparam int n_evicts   = 60;
    localparam int max_cycles = (n_stores + n_evicts) * 40;

    logic        clk;
    logic        reset;
    wt_req_t     wt_req;
    logic        wt_valid;
    logic        wt_ready;
    evict_req_t  evict_req;
    logic        evict_valid;
    logic        evict_ready;
    mem_beat_t   mem_beat;
    logic        mem_valid;
    logic        mem_ready;
    logic        write_idle;

    logic [31:0] rng_state = 32'h8480;
    mem_beat_t   st_q[$];           // store beats still owed to memory
    mem_beat_t   ev_q[$];           // two eviction beats per accepted line
    bit [7:0]    mem_img [65536];   // bytes memory received
    bit [7:0]    ref_img [65536];   // bytes from accepted requests
    bit          monitor_on;
    bit          wt_fire;           // store transfer at the coming edge
    bit          ev_fire;
    bit          pend;
    bit          pend_ev;
    mem_beat_t   held_beat;
    int          stores_issued;
    int          evicts_issued;
    int          cycle_cnt;
    int          bad_bytes;

    always #4 clk = ~clk;

    mem_write_port #(.wt_depth(wt_depth)) mem_write_port_inst (.*);

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_beat(input string name, input mem_beat_t got, input mem_beat_t exp);
        if (got !== exp)
        begin
            stop_with_failure($sformatf(
                "CHECK FAILED %s: got %h/%h/%h expected %h/%h/%h (addr/wdata/wstrb)",
                name, got.addr, got.wdata, got.wstrb, exp.addr, exp.wdata, exp.wstrb));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            stop_with_failure($sformatf("CHECK FAILED %s: got %h expected %h", name, got, exp));
        end
    endtask

    // word on both halves and strobe on the lane picked by addr bit 2
    function automatic mem_beat_t store_beat(input wt_req_t r);
        mem_beat_t b;
        b.addr  = {r.addr[15:3], 3'b000};
        b.wdata = {r.wdata, r.wdata};
        b.wstrb = r.addr[2] ? {r.wstrb, 4'h0} : {4'h0, r.wstrb};
        return b;
    endfunction

    function automatic mem_beat_t evict_beat(input evict_req_t r, input int k);
        mem_beat_t b;
        b.addr  = {r.line_addr, 4'h0} + 16'(8 * k);
        b.wdata = r.line_data[64*k +: 64];
        b.wstrb = 8'hff;
        return b;
    endfunction

    task automatic drive_requests();
        logic [31:0] r;
        r = next_random();
        if (wt_fire)
            wt_valid = 1'b0;
        if (!wt_valid && stores_issued < n_stores && r[0])
        begin
            wt_req.addr  = 16'(next_random()) & 16'h7fff;     // stores in the lower half
            wt_req.wstrb = r[7:4];
            wt_req.wdata = next_random();
            wt_valid     = 1'b1;
            stores_issued++;
        end
        if (ev_fire)
            evict_valid = 1'b0;
        if (!evict_valid && evicts_issued < n_evicts && r[11:8] < 4'd3)
        begin
            evict_req.line_addr = 12'h800 | 12'(next_random());  // lines in the upper half
            evict_req.line_data = {next_random(), next_random(), next_random(), next_random()};
            evict_valid         = 1'b1;
            evicts_issued++;
        end
    endtask

    // alternating light and heavy stall phases
    task automatic drive_mem_ready();
        logic [31:0] r;
        r = next_random();
        cycle_cnt++;
        mem_ready = cycle_cnt[6] ? (r[2:0] == 3'd0) : (r[1:0] != 2'd0);
    endtask

    always @(negedge clk)
    begin
        bit        src_ev;
        bit        exp_valid;
        if (monitor_on)
        begin
            src_ev    = pend ? pend_ev : (ev_q.size() != 0);   // pending beat keeps its source
            exp_valid = src_ev ? (ev_q.size() != 0) : (st_q.size() != 0);
            check_flag("mem_valid", mem_valid, exp_valid);
            if (mem_valid && ev_q.size() == 1 && !mem_beat.addr[15])
                stop_with_failure("store beat sent between the two beats of a line");
            if (pend)
                check_beat("mem_beat held", mem_beat, held_beat);
            else if (exp_valid)
                check_beat("mem_beat", mem_beat, src_ev ? ev_q[0] : st_q[0]);
            check_flag("wt_ready", wt_ready,
                       (st_q.size() < wt_depth) || (exp_valid && !src_ev && mem_ready));
            check_flag("evict_ready", evict_ready, ev_q.size() == 0);
            check_flag("write_idle", write_idle,
                       st_q.size() == 0 && ev_q.size() == 0 && !exp_valid);
            if (exp_valid && mem_ready)
            begin
                for (int i = 0; i < 8; i++)
                    if (mem_beat.wstrb[i])
                        mem_img[mem_beat.addr + 16'(i)] = mem_beat.wdata[8*i +: 8];
                if (src_ev)
                    void'(ev_q.pop_front());
                else
                    void'(st_q.pop_front());
            end
            pend      = exp_valid && !mem_ready;
            pend_ev   = src_ev;
            held_beat = mem_beat;
            wt_fire   = wt_valid && wt_ready;
            ev_fire   = evict_valid && evict_ready;
            if (wt_fire)
            begin
                st_q.push_back(store_beat(wt_req));
                for (int i = 0; i < 4; i++)
                    if (wt_req.wstrb[i])
                        ref_img[{wt_req.addr[15:2], 2'b00} + 16'(i)] = wt_req.wdata[8*i +: 8];
            end
            if (ev_fire)
            begin
                ev_q.push_back(evict_beat(evict_req, 0));
                ev_q.push_back(evict_beat(evict_req, 1));
                for (int i = 0; i < 16; i++)
                    ref_img[{evict_req.line_addr, 4'h0} + 16'(i)] = evict_req.line_data[8*i +: 8];
            end
        end
    end

    initial
    begin
        clk         = 1'b0;
        reset       = 1'b1;
        wt_req      = '0;
        wt_valid    = 1'b0;
        evict_req   = '0;
        evict_valid = 1'b0;
        mem_ready   = 1'b0;
        repeat (10) @(posedge clk);
        #1 reset = 1'b0;
        @(negedge clk);
        check_flag("mem_valid", mem_valid, 1'b0);
        check_flag("wt_ready", wt_ready, 1'b1);
        check_flag("evict_ready", evict_ready, 1'b1);
        check_flag("write_idle", write_idle, 1'b1);
        @(posedge clk);
        #1 monitor_on = 1'b1;
        while (stores_issued < n_stores || evicts_issued < n_evicts || wt_valid || evict_valid)
        begin
            drive_requests();
            drive_mem_ready();
            @(posedge clk);
            #1;
        end
        while (!write_idle)     // drain with inputs idle
        begin
            drive_mem_ready();
            @(posedge clk);
            #1;
        end
        check_flag("store queue empty", st_q.size() == 0, 1'b1);
        check_flag("eviction queue empty", ev_q.size() == 0, 1'b1);
        bad_bytes = 0;
        for (int a = 0; a < 65536; a++)
            if (mem_img[16'(a)] != ref_img[16'(a)])
                bad_bytes++;
        if (bad_bytes == 0)
        begin
            $display("*** PASSED ***");
            $finish;
        end
        else
        begin
            stop_with_failure($sformatf("memory image differs from reference in %0d bytes",
                                        bad_bytes));
        end
    end

    initial
    begin
        repeat (max_cycles) @(posedge clk);
        stop_with_failure($sformatf("timeout, run did not finish in %0d cycles", max_cycles));
    end

endmodule

`default_nettype wire

/* build.f */
logic/mem_types_pkg.sv
logic/fe_types_pkg.sv
logic/write_through_buffer.sv
logic/line_evict_serializer.sv
logic/mem_write_control.sv
logic/mem_write_port.sv
verif/mem_write_port_assertions.sv
verif/mem_write_port_tb.sv

/* Makefile */
VERILATOR ?= verilator
FILELIST  ?= build.f
TB_TOP    ?= mem_write_port_tb
RTL_TOP   ?= mem_write_port
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		-Mdir $(OBJ_DIR) -o V$(TB_TOP)
	./$(OBJ_DIR)/V$(TB_TOP) 2>&1 | tee $(LOG)
	@if grep -q -F '*** PASSED ***' $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
